// ==== fetch_pkg.sv ====
package fetch_pkg;

    localparam int XLEN      = 64;
    localparam int ILEN      = 32;
    localparam int AXI_DW    = 32;
    localparam int AXI_AW    = 32;   // register bus only, the rom bus is XLEN wide

    // instruction rom placement
    localparam logic [XLEN-1:0] ROM_BASE = 64'h0000_0000_8000_0000;
    localparam int ROM_WORDS = 64;
    localparam int ROM_IDX_W = $clog2(ROM_WORDS);

    // register map of the fetch csr block
    localparam logic [AXI_AW-1:0] REG_CTRL     = 32'h00;   // bit 0 run
    localparam logic [AXI_AW-1:0] REG_BOOT_LO  = 32'h08;
    localparam logic [AXI_AW-1:0] REG_BOOT_HI  = 32'h0C;
    localparam logic [AXI_AW-1:0] REG_MTVEC_LO = 32'h10;
    localparam logic [AXI_AW-1:0] REG_MTVEC_HI = 32'h14;
    localparam logic [AXI_AW-1:0] REG_COUNT    = 32'h18;   // read only

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // redirect request coming back from later stages
    typedef enum logic [2:0] {
        REDIR_NONE   = 3'd0,
        REDIR_JAL    = 3'd1,
        REDIR_BRANCH = 3'd2,
        REDIR_JALR   = 3'd3,
        REDIR_TRAP   = 3'd4
    } redir_op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_ADDR = 2'd1,   // arvalid up
        ST_DATA = 2'd2,   // waiting on rvalid
        ST_OUT  = 2'd3    // instruction presented
    } fetch_state_e;

    typedef struct packed {
        logic            run;
        logic [XLEN-1:0] boot_pc;
        logic [XLEN-1:0] mtvec;
    } fetch_cfg_t;

endpackage

// ==== axi_lite_rd_if.sv ====
interface axi_lite_rd_if;
    import fetch_pkg::*;

    logic              arvalid;
    logic              arready;
    logic [XLEN-1:0]   araddr;
    logic              rvalid;
    logic              rready;
    logic [AXI_DW-1:0] rdata;
    logic [1:0]        rresp;

    modport master (
        output arvalid,
        input  arready,
        output araddr,
        input  rvalid,
        output rready,
        input  rdata,
        input  rresp
    );

    modport slave (
        input  arvalid,
        output arready,
        input  araddr,
        output rvalid,
        input  rready,
        output rdata,
        output rresp
    );

endinterface

// ==== fetch_csr.sv ====
module fetch_csr (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            s_awvalid_i,
    output logic                            s_awready_o,
    input  logic [fetch_pkg::AXI_AW-1:0]    s_awaddr_i,
    input  logic                            s_wvalid_i,
    output logic                            s_wready_o,
    input  logic [fetch_pkg::AXI_DW-1:0]    s_wdata_i,
    input  logic [fetch_pkg::AXI_DW/8-1:0]  s_wstrb_i,
    output logic                            s_bvalid_o,
    input  logic                            s_bready_i,
    output logic [1:0]                      s_bresp_o,
    input  logic                            s_arvalid_i,
    output logic                            s_arready_o,
    input  logic [fetch_pkg::AXI_AW-1:0]    s_araddr_i,
    output logic                            s_rvalid_o,
    input  logic                            s_rready_i,
    output logic [fetch_pkg::AXI_DW-1:0]    s_rdata_o,
    output logic [1:0]                      s_rresp_o,
    output fetch_pkg::fetch_cfg_t           cfg_o,
    output logic                            boot_load_o,
    input  logic                            inst_fire_i
);
    import fetch_pkg::*;

    logic              wr_fire;
    logic              rd_fire;
    logic              run_q;
    logic              run_prev_q;
    logic [XLEN-1:0]   boot_pc_q;
    logic [XLEN-1:0]   mtvec_q;
    logic [AXI_DW-1:0] count_q;
    logic [AXI_DW-1:0] rd_word;
    logic [1:0]        rd_resp;

    // byte lane merge for partial writes
    function automatic logic [AXI_DW-1:0] merge_strb(input logic [AXI_DW-1:0]   old_w,
                                                     input logic [AXI_DW-1:0]   new_w,
                                                     input logic [AXI_DW/8-1:0] strb);
        logic [AXI_DW-1:0] res;
        res = old_w;
        for (int i = 0; i < AXI_DW/8; i++) begin
            if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

    // aw and w are taken together, one write in flight
    assign wr_fire     = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
    assign s_awready_o = wr_fire;
    assign s_wready_o  = wr_fire;

    assign s_arready_o = !s_rvalid_o;
    assign rd_fire     = s_arvalid_i && s_arready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q      <= 1'b0;
            boot_pc_q  <= ROM_BASE;
            mtvec_q    <= ROM_BASE;
            s_bvalid_o <= 1'b0;
            s_bresp_o  <= RESP_OKAY;
        end else if (wr_fire) begin
            s_bvalid_o <= 1'b1;
            s_bresp_o  <= RESP_OKAY;
            case (s_awaddr_i)
                REG_CTRL:     if (s_wstrb_i[0]) run_q <= s_wdata_i[0];
                REG_BOOT_LO:  boot_pc_q[AXI_DW-1:0] <=
                                  merge_strb(boot_pc_q[AXI_DW-1:0], s_wdata_i, s_wstrb_i);
                REG_BOOT_HI:  boot_pc_q[XLEN-1:AXI_DW] <=
                                  merge_strb(boot_pc_q[XLEN-1:AXI_DW], s_wdata_i, s_wstrb_i);
                REG_MTVEC_LO: mtvec_q[AXI_DW-1:0] <=
                                  merge_strb(mtvec_q[AXI_DW-1:0], s_wdata_i, s_wstrb_i);
                REG_MTVEC_HI: mtvec_q[XLEN-1:AXI_DW] <=
                                  merge_strb(mtvec_q[XLEN-1:AXI_DW], s_wdata_i, s_wstrb_i);
                default:      s_bresp_o <= RESP_SLVERR;   // count is read only
            endcase
        end else if (s_bvalid_o && s_bready_i) begin
            s_bvalid_o <= 1'b0;
        end
    end

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (s_araddr_i)
            REG_CTRL:     rd_word = {{(AXI_DW-1){1'b0}}, run_q};
            REG_BOOT_LO:  rd_word = boot_pc_q[AXI_DW-1:0];
            REG_BOOT_HI:  rd_word = boot_pc_q[XLEN-1:AXI_DW];
            REG_MTVEC_LO: rd_word = mtvec_q[AXI_DW-1:0];
            REG_MTVEC_HI: rd_word = mtvec_q[XLEN-1:AXI_DW];
            REG_COUNT:    rd_word = count_q;
            default:      rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s_rvalid_o <= 1'b0;
        end else if (rd_fire) begin
            s_rvalid_o <= 1'b1;
        end else if (s_rready_i) begin
            s_rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_rdata_o <= rd_word;
            s_rresp_o <= rd_resp;
        end
    end

    // run edge starts the core at the boot vector
    assign boot_load_o = run_q && !run_prev_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_prev_q <= 1'b0;
            count_q    <= '0;
        end else begin
            run_prev_q <= run_q;
            if (boot_load_o) count_q <= '0;
            else if (inst_fire_i) count_q <= count_q + 1'b1;
        end
    end

    assign cfg_o = '{run: run_q, boot_pc: boot_pc_q, mtvec: mtvec_q};

    a_bvalid_after_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(s_bvalid_o) |-> $past(s_awvalid_i && s_wvalid_i));

endmodule

// ==== fetch_unit.sv ====
module fetch_unit (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  fetch_pkg::fetch_cfg_t        cfg_i,
    input  logic                         boot_load_i,
    input  fetch_pkg::redir_op_e         redir_op_i,
    input  logic [fetch_pkg::XLEN-1:0]   redir_pc_i,
    input  logic [fetch_pkg::XLEN-1:0]   redir_imm_i,
    input  logic [fetch_pkg::XLEN-1:0]   redir_rs1_i,
    input  logic [fetch_pkg::XLEN-1:0]   redir_alu_i,
    input  logic                         hold_i,
    axi_lite_rd_if.master                mem,
    output logic                         inst_valid_o,
    input  logic                         inst_ready_i,
    output logic [fetch_pkg::ILEN-1:0]   inst_o,
    output logic [fetch_pkg::XLEN-1:0]   inst_pc_o,
    output logic                         inst_fault_o,
    output logic                         inst_fire_o
);
    import fetch_pkg::*;

    fetch_state_e    state_q;
    logic [XLEN-1:0] pc_q;        // next pc to fetch
    logic [XLEN-1:0] araddr_q;
    logic            epoch_q;
    logic            req_epoch_q; // epoch of the read in flight
    logic            redir_take;
    logic [XLEN-1:0] redir_target;
    logic [XLEN-1:0] jalr_sum;
    logic            flush;
    logic [XLEN-1:0] flush_pc;
    logic            issue_ok;
    logic            issue;
    logic            ar_fire;
    logic            r_fire;
    logic            r_keep;

    assign jalr_sum = redir_rs1_i + redir_imm_i;

    always_comb begin
        redir_take   = 1'b0;
        redir_target = redir_pc_i + redir_imm_i;
        case (redir_op_i)
            REDIR_JAL:    redir_take = 1'b1;
            REDIR_BRANCH: redir_take = (redir_alu_i == '0);   // not taken is ignored
            REDIR_JALR: begin
                redir_take   = 1'b1;
                redir_target = {jalr_sum[XLEN-1:1], 1'b0};
            end
            REDIR_TRAP: begin
                redir_take   = 1'b1;
                redir_target = cfg_i.mtvec;
            end
            default:      redir_take = 1'b0;
        endcase
    end

    // redirect beats boot load, both restart the stream
    assign flush    = redir_take || boot_load_i;
    assign flush_pc = redir_take ? redir_target : cfg_i.boot_pc;

    assign mem.arvalid = (state_q == ST_ADDR);
    assign mem.araddr  = araddr_q;
    assign mem.rready  = (state_q == ST_DATA);

    assign ar_fire     = mem.arvalid && mem.arready;
    assign r_fire      = mem.rvalid && mem.rready;
    assign r_keep      = r_fire && (req_epoch_q == epoch_q) && !flush;
    assign inst_fire_o = inst_valid_o && inst_ready_i;

    assign issue_ok = cfg_i.run && !hold_i && !flush;
    assign issue    = issue_ok && ((state_q == ST_IDLE) || (state_q == ST_OUT && inst_fire_o));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= ST_IDLE;
            pc_q         <= ROM_BASE;
            epoch_q      <= 1'b0;
            req_epoch_q  <= 1'b0;
            inst_valid_o <= 1'b0;
        end else begin
            if (flush) begin
                pc_q    <= flush_pc;
                epoch_q <= ~epoch_q;   // stale response gets dropped
            end else if (r_keep) begin
                pc_q <= pc_q + 'd4;
            end

            if (issue) req_epoch_q <= epoch_q;

            case (state_q)
                ST_IDLE: if (issue) state_q <= ST_ADDR;
                ST_ADDR: if (ar_fire) state_q <= ST_DATA;
                ST_DATA: if (r_fire) state_q <= r_keep ? ST_OUT : ST_IDLE;
                ST_OUT: begin
                    if (issue) state_q <= ST_ADDR;
                    else if (flush || inst_fire_o) state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase

            if (r_keep) inst_valid_o <= 1'b1;
            else if (flush || inst_fire_o) inst_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) araddr_q <= pc_q;
        if (r_keep) begin
            inst_o       <= mem.rdata;
            inst_pc_o    <= araddr_q;
            inst_fault_o <= (mem.rresp != RESP_OKAY);
        end
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem.arvalid && !mem.arready |=> mem.arvalid && $stable(mem.araddr));

    // held output survives back-pressure unless flushed
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_valid_o && !inst_ready_i && !flush |=>
            inst_valid_o && $stable(inst_o) && $stable(inst_pc_o));

endmodule

// ==== inst_rom.sv ====
module inst_rom (
    input  logic          clk,
    input  logic          rst_n_i,
    axi_lite_rd_if.slave  bus
);
    import fetch_pkg::*;

    logic [ILEN-1:0] rom_q [ROM_WORDS];
    logic [XLEN-1:0] offset;
    logic            in_range;
    logic            ar_fire;

    initial begin
        $readmemh("program.hex", rom_q);
    end

    assign offset   = bus.araddr - ROM_BASE;
    // below base wraps offset high, so one compare covers both ends
    assign in_range = (bus.araddr >= ROM_BASE)
                   && (offset < XLEN'(ROM_WORDS * 4))
                   && (bus.araddr[1:0] == 2'b00);

    assign bus.arready = !bus.rvalid;   // one response pending at most
    assign ar_fire     = bus.arvalid && bus.arready;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.rvalid <= 1'b0;
        end else if (ar_fire) begin
            bus.rvalid <= 1'b1;
        end else if (bus.rready) begin
            bus.rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            if (in_range) begin
                bus.rdata <= rom_q[offset[ROM_IDX_W+1:2]];
                bus.rresp <= RESP_OKAY;
            end else begin
                bus.rdata <= '0;
                bus.rresp <= RESP_SLVERR;
            end
        end
    end

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata) && $stable(bus.rresp));

endmodule

// ==== fetch_top.sv ====
module fetch_top (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            s_awvalid_i,
    output logic                            s_awready_o,
    input  logic [fetch_pkg::AXI_AW-1:0]    s_awaddr_i,
    input  logic                            s_wvalid_i,
    output logic                            s_wready_o,
    input  logic [fetch_pkg::AXI_DW-1:0]    s_wdata_i,
    input  logic [fetch_pkg::AXI_DW/8-1:0]  s_wstrb_i,
    output logic                            s_bvalid_o,
    input  logic                            s_bready_i,
    output logic [1:0]                      s_bresp_o,
    input  logic                            s_arvalid_i,
    output logic                            s_arready_o,
    input  logic [fetch_pkg::AXI_AW-1:0]    s_araddr_i,
    output logic                            s_rvalid_o,
    input  logic                            s_rready_i,
    output logic [fetch_pkg::AXI_DW-1:0]    s_rdata_o,
    output logic [1:0]                      s_rresp_o,
    input  fetch_pkg::redir_op_e            redir_op_i,
    input  logic [fetch_pkg::XLEN-1:0]      redir_pc_i,
    input  logic [fetch_pkg::XLEN-1:0]      redir_imm_i,
    input  logic [fetch_pkg::XLEN-1:0]      redir_rs1_i,
    input  logic [fetch_pkg::XLEN-1:0]      redir_alu_i,
    input  logic                            hold_i,
    output logic                            inst_valid_o,
    input  logic                            inst_ready_i,
    output logic [fetch_pkg::ILEN-1:0]      inst_o,
    output logic [fetch_pkg::XLEN-1:0]      inst_pc_o,
    output logic                            inst_fault_o
);
    import fetch_pkg::*;

    fetch_cfg_t cfg;
    logic       boot_load;
    logic       inst_fire;   // delivered instruction, counted in csr

    axi_lite_rd_if rom_bus ();

    fetch_csr u_csr (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .s_awvalid_i  (s_awvalid_i),
        .s_awready_o  (s_awready_o),
        .s_awaddr_i   (s_awaddr_i),
        .s_wvalid_i   (s_wvalid_i),
        .s_wready_o   (s_wready_o),
        .s_wdata_i    (s_wdata_i),
        .s_wstrb_i    (s_wstrb_i),
        .s_bvalid_o   (s_bvalid_o),
        .s_bready_i   (s_bready_i),
        .s_bresp_o    (s_bresp_o),
        .s_arvalid_i  (s_arvalid_i),
        .s_arready_o  (s_arready_o),
        .s_araddr_i   (s_araddr_i),
        .s_rvalid_o   (s_rvalid_o),
        .s_rready_i   (s_rready_i),
        .s_rdata_o    (s_rdata_o),
        .s_rresp_o    (s_rresp_o),
        .cfg_o        (cfg),
        .boot_load_o  (boot_load),
        .inst_fire_i  (inst_fire)
    );

    fetch_unit u_fetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cfg_i        (cfg),
        .boot_load_i  (boot_load),
        .redir_op_i   (redir_op_i),
        .redir_pc_i   (redir_pc_i),
        .redir_imm_i  (redir_imm_i),
        .redir_rs1_i  (redir_rs1_i),
        .redir_alu_i  (redir_alu_i),
        .hold_i       (hold_i),
        .mem          (rom_bus),
        .inst_valid_o (inst_valid_o),
        .inst_ready_i (inst_ready_i),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o),
        .inst_fault_o (inst_fault_o),
        .inst_fire_o  (inst_fire)
    );

    inst_rom u_rom (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (rom_bus)
    );

endmodule

// ==== tb_fetch.sv ====
module tb_fetch;
    timeunit 1ns;
    timeprecision 100ps;
    import fetch_pkg::*;

    // about 60 fetches under 10 cycles each plus register traffic, with wide margin
    localparam int MAX_CYCLES = 4000;

    logic                clk;
    logic                rst_n_i;
    logic                s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
    logic                s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
    logic [AXI_AW-1:0]   s_awaddr_i, s_araddr_i;
    logic [AXI_DW-1:0]   s_wdata_i, s_rdata_o;
    logic [AXI_DW/8-1:0] s_wstrb_i;
    logic [1:0]          s_bresp_o, s_rresp_o;
    redir_op_e           redir_op_i;
    logic [XLEN-1:0]     redir_pc_i, redir_imm_i, redir_rs1_i, redir_alu_i;
    logic                hold_i, inst_ready_i, inst_valid_o, inst_fault_o;
    logic [ILEN-1:0]     inst_o;
    logic [XLEN-1:0]     inst_pc_o;

    logic [ILEN-1:0] model_mem [ROM_WORDS];
    logic [XLEN-1:0] last_pc;     // pc of the last delivered instruction
    int              errors;
    int              checks;
    int              fire_cnt;    // handshakes since the last boot load
    int              cycles;
    integer          seed;

    fetch_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic bit in_rom(input logic [XLEN-1:0] pc);
        return (pc >= ROM_BASE) && (pc - ROM_BASE < ROM_WORDS * 4) && (pc[1:0] == 2'b00);
    endfunction

    // expected fetch result, zero data outside the rom
    function automatic logic [ILEN-1:0] model_word(input logic [XLEN-1:0] pc);
        if (!in_rom(pc)) return '0;
        return model_mem[int'((pc - ROM_BASE) >> 2)];
    endfunction

    task automatic check_inst(input string what, input logic [ILEN-1:0] got,
                              input logic [ILEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pc(input string what, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0d ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input logic [AXI_DW-1:0] got,
                              input logic [AXI_DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0d ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic reg_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data);
        s_awvalid_i = 1'b1;
        s_awaddr_i  = addr;
        s_wvalid_i  = 1'b1;
        s_wdata_i   = data;
        s_wstrb_i   = '1;
        @(negedge clk);
        while (!s_awready_o) @(negedge clk);
        check_flag("wready with awready", s_wready_o, 1'b1);
        @(posedge clk);
        #1;
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b1;
        while (!s_bvalid_o) begin
            @(posedge clk);
            #1;
        end
        check_resp("bresp", s_bresp_o, RESP_OKAY);
        @(posedge clk);
        #1;
        s_bready_i = 1'b0;
    endtask

    task automatic reg_read(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data,
                            output logic [1:0] resp);
        s_arvalid_i = 1'b1;
        s_araddr_i  = addr;
        @(negedge clk);
        while (!s_arready_o) @(negedge clk);
        @(posedge clk);
        #1;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b1;
        while (!s_rvalid_o) begin
            @(posedge clk);
            #1;
        end
        data = s_rdata_o;
        resp = s_rresp_o;
        @(posedge clk);
        #1;
        s_rready_i = 1'b0;
    endtask

    // take one instruction, ready only while waiting so no handshake goes unseen
    task automatic expect_next(input logic [XLEN-1:0] exp_pc);
        inst_ready_i = 1'b1;
        @(negedge clk);
        while (!inst_valid_o) @(negedge clk);
        check_pc("inst_pc_o", inst_pc_o, exp_pc);
        check_inst("inst_o", inst_o, model_word(exp_pc));
        check_flag("inst_fault_o", inst_fault_o, !in_rom(exp_pc));
        @(posedge clk);
        #1;
        inst_ready_i = 1'b0;
        fire_cnt++;
        last_pc = exp_pc;
    endtask

    task automatic redirect_to(input redir_op_e op, input logic [XLEN-1:0] pc,
                               input logic [XLEN-1:0] imm, input logic [XLEN-1:0] rs1,
                               input logic [XLEN-1:0] alu, input logic [XLEN-1:0] exp_pc);
        redir_op_i  = op;
        redir_pc_i  = pc;
        redir_imm_i = imm;
        redir_rs1_i = rs1;
        redir_alu_i = alu;
        @(posedge clk);   // redirect taken on this edge
        #1;
        redir_op_i = REDIR_NONE;
        expect_next(exp_pc);
    endtask

    task automatic access_registers();
        logic [AXI_DW-1:0] data;
        logic [1:0]        resp;
        reg_read(REG_CTRL, data, resp);
        check_word("ctrl after reset", data, '0);
        check_resp("ctrl rresp", resp, RESP_OKAY);
        reg_write(REG_BOOT_LO, 32'h1234_5678);
        reg_write(REG_BOOT_HI, 32'h0000_00ab);
        reg_read(REG_BOOT_LO, data, resp);
        check_word("boot lo", data, 32'h1234_5678);
        reg_read(REG_BOOT_HI, data, resp);
        check_word("boot hi", data, 32'h0000_00ab);
        reg_write(REG_MTVEC_LO, ROM_BASE[31:0] + 32'h80);
        reg_write(REG_MTVEC_HI, ROM_BASE[63:32]);
        reg_read(REG_MTVEC_LO, data, resp);
        check_word("mtvec lo", data, ROM_BASE[31:0] + 32'h80);
        reg_read(REG_MTVEC_HI, data, resp);
        check_word("mtvec hi", data, ROM_BASE[63:32]);
        reg_read(32'h1C, data, resp);   // hole in the map
        check_resp("unknown offset rresp", resp, RESP_SLVERR);
        reg_write(REG_BOOT_LO, ROM_BASE[31:0]);
        reg_write(REG_BOOT_HI, ROM_BASE[63:32]);
    endtask

    task automatic run_sequential();
        fire_cnt = 0;
        reg_write(REG_CTRL, 32'h1);   // rising run loads the boot vector
        last_pc = ROM_BASE - 64'd4;
        for (int i = 0; i < 20; i++) begin
            expect_next(last_pc + 64'd4);
        end
    endtask

    task automatic apply_redirects();
        logic [XLEN-1:0] rs1;
        rs1 = ROM_BASE + 64'h91;
        redirect_to(REDIR_JAL, last_pc, 64'h20, '0, '0, last_pc + 64'h20);
        redirect_to(REDIR_BRANCH, last_pc, -64'd64, '0, '0, last_pc - 64'd64);
        redirect_to(REDIR_BRANCH, last_pc, 64'h10, '0, 64'd5, last_pc + 64'd4);  // not taken
        redirect_to(REDIR_JALR, last_pc, 64'h10, rs1, '0, (rs1 + 64'h10) & ~64'h1);
        redirect_to(REDIR_TRAP, last_pc, '0, '0, '0, ROM_BASE + 64'h80);
    endtask

    task automatic random_stalls(input int n);
        logic [ILEN-1:0] held_inst;
        logic [XLEN-1:0] held_pc;
        logic            stalled;
        int              got;
        stalled = 1'b0;
        got     = 0;
        while (got < n) begin
            inst_ready_i = ($random(seed) & 3) != 0;
            hold_i       = ($random(seed) & 3) == 0;
            @(negedge clk);
            if (stalled) begin
                check_flag("valid while stalled", inst_valid_o, 1'b1);
                check_inst("inst while stalled", inst_o, held_inst);
                check_pc("pc while stalled", inst_pc_o, held_pc);
            end
            stalled   = inst_valid_o && !inst_ready_i;
            held_inst = inst_o;
            held_pc   = inst_pc_o;
            if (inst_valid_o && inst_ready_i) begin
                check_pc("pc order", inst_pc_o, last_pc + 64'd4);
                check_inst("inst data", inst_o, model_word(last_pc + 64'd4));
                last_pc = last_pc + 64'd4;
                fire_cnt++;
                got++;
            end
            @(posedge clk);
            #1;
        end
        inst_ready_i = 1'b0;
        hold_i       = 1'b0;
    endtask

    task automatic bad_targets();
        redirect_to(REDIR_JAL, last_pc, 64'h100, '0, '0, last_pc + 64'h100);   // past the end
        redirect_to(REDIR_JAL, ROM_BASE, 64'h6, '0, '0, ROM_BASE + 64'h6);     // misaligned
        redirect_to(REDIR_JAL, ROM_BASE, 64'h0, '0, '0, ROM_BASE);
    endtask

    task automatic read_count();
        logic [AXI_DW-1:0] data;
        logic [1:0]        resp;
        reg_read(REG_COUNT, data, resp);
        check_resp("count rresp", resp, RESP_OKAY);
        check_word("delivered count", data, AXI_DW'(fire_cnt));
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        errors       = 0;
        checks       = 0;
        fire_cnt     = 0;
        seed         = 1;
        last_pc      = ROM_BASE;
        rst_n_i      = 1'b0;
        s_awvalid_i  = 1'b0;
        s_awaddr_i   = '0;
        s_wvalid_i   = 1'b0;
        s_wdata_i    = '0;
        s_wstrb_i    = '0;
        s_bready_i   = 1'b0;
        s_arvalid_i  = 1'b0;
        s_araddr_i   = '0;
        s_rready_i   = 1'b0;
        redir_op_i   = REDIR_NONE;
        redir_pc_i   = '0;
        redir_imm_i  = '0;
        redir_rs1_i  = '0;
        redir_alu_i  = '0;
        hold_i       = 1'b0;
        inst_ready_i = 1'b0;
        $readmemh("program.hex", model_mem);
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        check_flag("inst_valid_o after reset", inst_valid_o, 1'b0);
        check_flag("s_bvalid_o after reset", s_bvalid_o, 1'b0);
        check_flag("s_rvalid_o after reset", s_rvalid_o, 1'b0);

        access_registers();
        run_sequential();
        apply_redirects();
        random_stalls(30);
        bad_targets();
        read_count();

        $display("run done: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== program.hex ====
// one 32-bit instruction word per line, word 0 sits at ROM_BASE
// each word is addi x1, x0, n with n the word index
00000093
00100093
00200093
00300093
00400093
00500093
00600093
00700093
00800093
00900093
00a00093
00b00093
00c00093
00d00093
00e00093
00f00093
01000093
01100093
01200093
01300093
01400093
01500093
01600093
01700093
01800093
01900093
01a00093
01b00093
01c00093
01d00093
01e00093
01f00093
02000093
02100093
02200093
02300093
02400093
02500093
02600093
02700093
02800093
02900093
02a00093
02b00093
02c00093
02d00093
02e00093
02f00093
03000093
03100093
03200093
03300093
03400093
03500093
03600093
03700093
03800093
03900093
03a00093
03b00093
03c00093
03d00093
03e00093
03f00093

// ==== sources.f ====
fetch_pkg.sv
axi_lite_rd_if.sv
fetch_csr.sv
fetch_unit.sv
inst_rom.sv
fetch_top.sv
tb_fetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_fetch
FILELIST  ?= sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
